//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= ooo_backend_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee /dev/stderr | grep -q "^Test OK$$"

clean:
	rm -rf $(OBJ_DIR)

//--- flist.f
+incdir+include
src/ooo_pkg.sv
src/cdb_arbiter.sv
src/alu_unit.sv
src/mem_unit.sv
src/reorder_buffer.sv
src/ooo_backend_top.sv
verification/commit_checker.sv
verification/ooo_backend_tb.sv

//--- include/ooo_settings.svh
`ifndef OOO_SETTINGS_SVH
`define OOO_SETTINGS_SVH

`define OOO_XLEN       32  // data and address width.
`define OOO_ROB_DEPTH  7   // usable entries, tags run 1 to 7.
`define OOO_DMEM_WORDS 64  // data memory size in words.

`endif

//--- src/alu_unit.sv
module alu_unit (
    input  logic               clk,
    input  logic               rst,
    input  ooo_pkg::dispatch_t dispatch,
    input  logic               dispatch_valid,
    input  ooo_pkg::cdb_t      cdb,
    input  logic               grant,
    output ooo_pkg::cdb_t      request,
    output logic               busy
);
    ooo_pkg::dispatch_t slot;
    logic               held;
    ooo_pkg::operand_t  op1, op2;

    function automatic ooo_pkg::word_t execute(ooo_pkg::op_e op, ooo_pkg::word_t a,
                                               ooo_pkg::word_t b, ooo_pkg::word_t imm);
        case (op)
            ooo_pkg::op_add:  return a + b;
            ooo_pkg::op_sub:  return a - b;
            ooo_pkg::op_and:  return a & b;
            ooo_pkg::op_or:   return a | b;
            ooo_pkg::op_xor:  return a ^ b;
            ooo_pkg::op_sll:  return a << b[4:0];
            ooo_pkg::op_srl:  return a >> b[4:0];
            ooo_pkg::op_sra:  return ooo_pkg::word_t'($signed(a) >>> b[4:0]);
            ooo_pkg::op_slt:  return ooo_pkg::word_t'($signed(a) < $signed(b));
            ooo_pkg::op_sltu: return ooo_pkg::word_t'(a < b);
            ooo_pkg::op_beq:  return ooo_pkg::word_t'(a == b);  // 1 means taken.
            ooo_pkg::op_bne:  return ooo_pkg::word_t'(a != b);
            ooo_pkg::op_blt:  return ooo_pkg::word_t'($signed(a) < $signed(b));
            ooo_pkg::op_bge:  return ooo_pkg::word_t'($signed(a) >= $signed(b));
            ooo_pkg::op_bltu: return ooo_pkg::word_t'(a < b);
            ooo_pkg::op_bgeu: return ooo_pkg::word_t'(a >= b);
            ooo_pkg::op_jalr: return (a + imm) & ~ooo_pkg::word_t'(1);  // jump target.
            default:          return '0;
        endcase
    endfunction

    assign op1 = ooo_pkg::snoop(slot.value1, slot.tag1, cdb);
    assign op2 = ooo_pkg::snoop(slot.value2, slot.tag2, cdb);
    assign busy = held || request.valid;

    always_ff @(posedge clk) begin
        if (!rst) begin
            held <= 1'b0;
            request <= '0;
        end else begin
            if (dispatch_valid) begin
                held <= 1'b1;
                slot <= dispatch;
            end else if (held) begin
                slot.value1 <= op1.value;
                slot.tag1 <= op1.tag;
                slot.value2 <= op2.value;
                slot.tag2 <= op2.tag;
                if (op1.tag == '0 && op2.tag == '0) begin
                    held <= 1'b0;
                    request.valid <= 1'b1;
                    request.tag <= slot.tag;
                    request.value <= execute(slot.op, op1.value, op2.value, slot.imm);
                end
            end
            if (grant) begin
                request.valid <= 1'b0;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst)
        request.valid && !grant |=> request == $past(request))
        else $error("ALU request changed before its grant.");

endmodule

//--- src/cdb_arbiter.sv
module cdb_arbiter (
    input  logic          clk,
    input  logic          rst,
    input  ooo_pkg::cdb_t alu_request,
    input  ooo_pkg::cdb_t mem_request,
    output ooo_pkg::cdb_t cdb,
    output logic          alu_grant,
    output logic          mem_grant
);
    logic last_mem;  // memory unit won the last contested cycle.
    logic contested;

    assign contested = alu_request.valid && mem_request.valid;
    assign alu_grant = alu_request.valid && (!mem_request.valid || last_mem);
    assign mem_grant = mem_request.valid && (!alu_request.valid || !last_mem);
    assign cdb = alu_grant ? alu_request : (mem_grant ? mem_request : ooo_pkg::cdb_t'('0));

    always_ff @(posedge clk) begin
        if (!rst) begin
            last_mem <= 1'b1;
        end else if (contested) begin
            last_mem <= mem_grant;
        end
    end

    // a request that loses a contested cycle wins the next one.
    assert property (@(posedge clk) disable iff (!rst)
        alu_request.valid && !alu_grant |=> alu_grant)
        else $error("ALU request passed over twice in a row.");

    assert property (@(posedge clk) disable iff (!rst)
        mem_request.valid && !mem_grant |=> mem_grant)
        else $error("memory request passed over twice in a row.");

endmodule

//--- src/mem_unit.sv
`include "ooo_settings.svh"

module mem_unit (
    input  logic               clk,
    input  logic               rst,
    input  ooo_pkg::dispatch_t dispatch,
    input  logic               dispatch_valid,
    input  ooo_pkg::cdb_t      cdb,
    input  ooo_pkg::rob_tag_t  mem_go,
    input  logic               grant,
    output ooo_pkg::cdb_t      request,
    output logic               busy
);
    localparam int words = `OOO_DMEM_WORDS;
    localparam int index_bits = $clog2(words);

    ooo_pkg::word_t        dmem [words];
    ooo_pkg::dispatch_t    slot;
    logic                  held, loaded_valid, go;
    ooo_pkg::word_t        loaded, addr;
    ooo_pkg::operand_t     base, data;
    logic [index_bits-1:0] index;

    assign base = ooo_pkg::snoop(slot.value1, slot.tag1, cdb);
    assign data = ooo_pkg::snoop(slot.value2, slot.tag2, cdb);
    assign addr = base.value + slot.imm;
    assign index = addr[index_bits+1:2];  // word addressed.
    assign go = held && mem_go != '0 && mem_go == slot.tag;
    assign busy = held || loaded_valid || request.valid;

    always_ff @(posedge clk) begin
        if (go) begin
            if (slot.op == ooo_pkg::op_sw) begin
                dmem[index] <= data.value;
            end
            loaded <= (slot.op == ooo_pkg::op_sw) ? '0 : dmem[index];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            held <= 1'b0;
            loaded_valid <= 1'b0;
            request <= '0;
        end else begin
            loaded_valid <= go;
            if (dispatch_valid) begin
                held <= 1'b1;
                slot <= dispatch;
            end else if (held) begin
                slot.value1 <= base.value;
                slot.tag1 <= base.tag;
                slot.value2 <= data.value;
                slot.tag2 <= data.tag;
                if (go) begin
                    held <= 1'b0;
                end
            end
            if (loaded_valid) begin
                request <= '{valid: 1'b1, tag: slot.tag, value: loaded};
            end
            if (grant) begin
                request.valid <= 1'b0;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst)
        mem_go != '0 |-> held && mem_go == slot.tag)
        else $error("memory go for tag %0d not held by the unit.", mem_go);

    // older producers have all committed once the entry is at the head.
    assert property (@(posedge clk) disable iff (!rst)
        go |-> base.tag == '0 && data.tag == '0)
        else $error("memory access with an unresolved operand.");

endmodule

//--- src/ooo_backend_top.sv
module ooo_backend_top (
    input  logic               clk,
    input  logic               rst,
    input  ooo_pkg::issue_t    issue,
    input  logic               issue_valid,
    output logic               full,
    output ooo_pkg::rob_tag_t  issued_tag,
    output ooo_pkg::commit_t   commit,
    output ooo_pkg::redirect_t redirect
);
    ooo_pkg::dispatch_t alu_dispatch, mem_dispatch;
    logic               alu_dispatch_valid, mem_dispatch_valid;
    ooo_pkg::rob_tag_t  mem_go;
    ooo_pkg::cdb_t      alu_request, mem_request, cdb;
    logic               alu_busy, mem_busy, alu_grant, mem_grant;

    reorder_buffer u_rob (
        .clk                (clk),
        .rst                (rst),
        .issue              (issue),
        .issue_valid        (issue_valid),
        .cdb                (cdb),
        .alu_busy           (alu_busy),
        .mem_busy           (mem_busy),
        .full               (full),
        .issued_tag         (issued_tag),
        .alu_dispatch       (alu_dispatch),
        .alu_dispatch_valid (alu_dispatch_valid),
        .mem_dispatch       (mem_dispatch),
        .mem_dispatch_valid (mem_dispatch_valid),
        .mem_go             (mem_go),
        .commit             (commit),
        .redirect           (redirect)
    );

    alu_unit u_alu (
        .clk            (clk),
        .rst            (rst),
        .dispatch       (alu_dispatch),
        .dispatch_valid (alu_dispatch_valid),
        .cdb            (cdb),
        .grant          (alu_grant),
        .request        (alu_request),
        .busy           (alu_busy)
    );

    mem_unit u_mem (
        .clk            (clk),
        .rst            (rst),
        .dispatch       (mem_dispatch),
        .dispatch_valid (mem_dispatch_valid),
        .cdb            (cdb),
        .mem_go         (mem_go),
        .grant          (mem_grant),
        .request        (mem_request),
        .busy           (mem_busy)
    );

    cdb_arbiter u_arb (
        .clk         (clk),
        .rst         (rst),
        .alu_request (alu_request),
        .mem_request (mem_request),
        .cdb         (cdb),
        .alu_grant   (alu_grant),
        .mem_grant   (mem_grant)
    );

endmodule

//--- src/ooo_pkg.sv
`include "ooo_settings.svh"

package ooo_pkg;

    typedef logic [`OOO_XLEN-1:0] word_t;
    typedef logic [2:0] rob_tag_t;  // 0 means no producer.

    typedef enum logic [4:0] {
        op_add   = 5'b00000,
        op_and   = 5'b00001,
        op_or    = 5'b00010,
        op_sll   = 5'b00011,
        op_srl   = 5'b00100,
        op_slt   = 5'b00101,
        op_sltu  = 5'b00110,
        op_sra   = 5'b00111,
        op_sub   = 5'b01000,
        op_xor   = 5'b01001,
        op_beq   = 5'b01010,
        op_bge   = 5'b01011,
        op_bne   = 5'b01100,
        op_bgeu  = 5'b01101,
        op_lui   = 5'b01110,
        op_auipc = 5'b01111,
        op_jal   = 5'b10000,
        op_jalr  = 5'b10001,
        op_lw    = 5'b10100,
        op_sw    = 5'b11001,
        op_blt   = 5'b11010,
        op_bltu  = 5'b11011,
        op_nop   = 5'b11111
    } op_e;

    typedef enum logic [1:0] {
        redir_branch = 2'd0,
        redir_jal    = 2'd1,
        redir_jalr   = 2'd2
    } redirect_kind_e;

    typedef struct packed {
        op_e        op;
        logic [4:0] rd;
        word_t      pc;
        word_t      imm;
        logic       has_imm;
        word_t      value1;
        word_t      value2;
        rob_tag_t   tag1;
        rob_tag_t   tag2;
    } issue_t;

    typedef struct packed {
        op_e      op;
        rob_tag_t tag;
        word_t    value1;
        rob_tag_t tag1;
        word_t    value2;
        rob_tag_t tag2;
        word_t    imm;
        word_t    pc;
    } dispatch_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        word_t    value;  // branches carry 1 for taken.
    } cdb_t;

    typedef struct packed {
        logic       valid;
        logic [4:0] rd;
        rob_tag_t   tag;
        word_t      value;
    } commit_t;

    typedef struct packed {
        logic           valid;
        redirect_kind_e kind;
        word_t          target;
    } redirect_t;

    typedef struct packed {
        word_t    value;
        rob_tag_t tag;  // still waiting when nonzero.
    } operand_t;

    // picks an operand off the bus when its producer broadcasts.
    function automatic operand_t snoop(word_t value, rob_tag_t tag, cdb_t bus);
        operand_t result;
        result.value = value;
        result.tag = tag;
        if (tag != '0 && bus.valid && bus.tag == tag) begin
            result.value = bus.value;
            result.tag = '0;
        end
        return result;
    endfunction

    function automatic logic is_branch(op_e op);
        return op inside {op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu};
    endfunction

    function automatic logic is_mem(op_e op);
        return op inside {op_lw, op_sw};
    endfunction

endpackage

//--- src/reorder_buffer.sv
`include "ooo_settings.svh"

module reorder_buffer (
    input  logic                 clk,
    input  logic                 rst,
    input  ooo_pkg::issue_t      issue,
    input  logic                 issue_valid,
    input  ooo_pkg::cdb_t        cdb,
    input  logic                 alu_busy,
    input  logic                 mem_busy,
    output logic                 full,
    output ooo_pkg::rob_tag_t    issued_tag,
    output ooo_pkg::dispatch_t   alu_dispatch,
    output logic                 alu_dispatch_valid,
    output ooo_pkg::dispatch_t   mem_dispatch,
    output logic                 mem_dispatch_valid,
    output ooo_pkg::rob_tag_t    mem_go,
    output ooo_pkg::commit_t     commit,
    output ooo_pkg::redirect_t   redirect
);
    localparam int depth = `OOO_ROB_DEPTH;

    localparam logic [1:0] st_wait      = 2'd0;
    localparam logic [1:0] st_addr      = 2'd1;  // memory entry handed to the unit.
    localparam logic [1:0] st_not_taken = 2'd2;
    localparam logic [1:0] st_done      = 2'd3;

    ooo_pkg::op_e      ent_op    [1:depth];
    logic [4:0]        ent_rd    [1:depth];
    ooo_pkg::word_t    ent_pc    [1:depth];
    ooo_pkg::word_t    ent_imm   [1:depth];
    ooo_pkg::word_t    ent_value [1:depth];
    ooo_pkg::word_t    ent_v1    [1:depth];
    ooo_pkg::word_t    ent_v2    [1:depth];
    ooo_pkg::rob_tag_t ent_t1    [1:depth];
    ooo_pkg::rob_tag_t ent_t2    [1:depth];
    logic [1:0]        ent_state [1:depth];
    logic              ent_busy  [1:depth];
    logic              ent_sent  [1:depth];

    ooo_pkg::operand_t res1 [1:depth];
    ooo_pkg::operand_t res2 [1:depth];
    ooo_pkg::operand_t iss1, iss2;
    ooo_pkg::rob_tag_t head, tail, alu_sel, mem_sel;
    logic [2:0]        count;
    logic              head_ready, at_alloc;
    ooo_pkg::word_t    alloc_value;

    function automatic ooo_pkg::rob_tag_t next_tag(ooo_pkg::rob_tag_t t);
        return (int'(t) == depth) ? ooo_pkg::rob_tag_t'(1) : t + 1'b1;
    endfunction

    // finished entries and the current broadcast both supply a value.
    function automatic ooo_pkg::operand_t lookup(ooo_pkg::word_t value,
                                                 ooo_pkg::rob_tag_t tag);
        ooo_pkg::operand_t result;
        result = ooo_pkg::snoop(value, tag, cdb);
        if (tag != '0 && ent_state[tag] == st_done) begin
            result.value = ent_value[tag];
            result.tag = '0;
        end
        return result;
    endfunction

    function automatic ooo_pkg::dispatch_t make_dispatch(ooo_pkg::rob_tag_t t);
        ooo_pkg::dispatch_t d;
        d.op = ent_op[t];
        d.tag = t;
        d.value1 = res1[t].value;
        d.tag1 = res1[t].tag;
        d.value2 = res2[t].value;
        d.tag2 = res2[t].tag;
        d.imm = ent_imm[t];
        d.pc = ent_pc[t];
        return d;
    endfunction

    assign full = count >= 3'd5;
    assign at_alloc = issue.op inside {ooo_pkg::op_lui, ooo_pkg::op_auipc, ooo_pkg::op_jal};
    assign head_ready = ent_busy[head] && (ent_state[head] inside {st_done, st_not_taken});
    assign mem_go = (ent_busy[head] && ent_state[head] == st_addr) ? head : '0;
    assign alu_dispatch_valid = alu_sel != '0 && !alu_busy;
    assign mem_dispatch_valid = mem_sel != '0 && !mem_busy;

    always_comb begin
        iss1 = lookup(issue.value1, issue.tag1);
        iss2 = lookup(issue.value2, issue.tag2);
        if (issue.has_imm && !ooo_pkg::is_branch(issue.op) && issue.op != ooo_pkg::op_sw) begin
            iss2 = '{value: issue.imm, tag: '0};
        end
        case (issue.op)
            ooo_pkg::op_lui:   alloc_value = issue.imm;
            ooo_pkg::op_auipc: alloc_value = issue.pc + issue.imm;
            ooo_pkg::op_jal:   alloc_value = issue.pc + 32'd4;  // link value for consumers.
            default:           alloc_value = '0;
        endcase
    end

    always_comb begin
        int slot;
        alu_sel = '0;
        mem_sel = '0;
        for (int i = 1; i <= depth; i++) begin
            res1[i] = lookup(ent_v1[i], ent_t1[i]);
            res2[i] = lookup(ent_v2[i], ent_t2[i]);
        end
        for (int i = 0; i < depth; i++) begin  // walks from oldest to newest.
            slot = int'(head) + i;
            if (slot > depth) begin
                slot = slot - depth;
            end
            if (ent_busy[slot] && !ent_sent[slot]) begin
                if (ooo_pkg::is_mem(ent_op[slot])) begin
                    if (mem_sel == '0) begin
                        mem_sel = slot[2:0];
                    end
                end else if (alu_sel == '0) begin
                    alu_sel = slot[2:0];
                end
            end
        end
        alu_dispatch = (alu_sel != '0) ? make_dispatch(alu_sel) : '0;
        mem_dispatch = (mem_sel != '0) ? make_dispatch(mem_sel) : '0;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            head <= ooo_pkg::rob_tag_t'(1);
            tail <= ooo_pkg::rob_tag_t'(1);
            count <= '0;
            issued_tag <= '0;
            commit <= '0;
            redirect <= '0;
            for (int i = 1; i <= depth; i++) begin
                ent_busy[i] <= 1'b0;
                ent_sent[i] <= 1'b0;
                ent_state[i] <= st_wait;
            end
        end else begin
            for (int i = 1; i <= depth; i++) begin
                ent_v1[i] <= res1[i].value;
                ent_t1[i] <= res1[i].tag;
                ent_v2[i] <= res2[i].value;
                ent_t2[i] <= res2[i].tag;
            end
            if (cdb.valid) begin
                ent_value[cdb.tag] <= cdb.value;
                ent_state[cdb.tag] <= (ooo_pkg::is_branch(ent_op[cdb.tag]) && cdb.value == '0)
                                      ? st_not_taken : st_done;
            end
            if (alu_dispatch_valid) begin
                ent_sent[alu_sel] <= 1'b1;
            end
            if (mem_dispatch_valid) begin
                ent_sent[mem_sel] <= 1'b1;
                ent_state[mem_sel] <= st_addr;
            end
            if (mem_go != '0) begin
                ent_state[head] <= st_wait;  // access under way in the memory unit.
            end
            if (issue_valid) begin
                ent_busy[tail] <= 1'b1;
                ent_sent[tail] <= at_alloc;
                ent_state[tail] <= at_alloc ? st_done : st_wait;
                ent_op[tail] <= issue.op;
                ent_rd[tail] <= issue.rd;
                ent_pc[tail] <= issue.pc;
                ent_imm[tail] <= issue.imm;
                ent_value[tail] <= alloc_value;
                ent_v1[tail] <= iss1.value;
                ent_t1[tail] <= iss1.tag;
                ent_v2[tail] <= iss2.value;
                ent_t2[tail] <= iss2.tag;
                issued_tag <= tail;
                tail <= next_tag(tail);
            end
            commit <= '0;
            redirect <= '0;
            if (head_ready) begin
                ent_busy[head] <= 1'b0;
                head <= next_tag(head);
                if (ent_state[head] == st_done) begin
                    commit.valid <= ent_rd[head] != '0;
                    commit.rd <= ent_rd[head];
                    commit.tag <= head;
                    commit.value <= (ent_op[head] inside {ooo_pkg::op_jal, ooo_pkg::op_jalr})
                                    ? ent_pc[head] + 32'd4 : ent_value[head];
                    redirect.valid <= ooo_pkg::is_branch(ent_op[head])
                                      || ent_op[head] inside {ooo_pkg::op_jal, ooo_pkg::op_jalr};
                    redirect.kind <= ooo_pkg::is_branch(ent_op[head]) ? ooo_pkg::redir_branch
                                   : (ent_op[head] == ooo_pkg::op_jal) ? ooo_pkg::redir_jal
                                   : ooo_pkg::redir_jalr;
                    redirect.target <= (ent_op[head] == ooo_pkg::op_jalr)
                                       ? ent_value[head] : ent_pc[head] + ent_imm[head];
                end
            end
            count <= count + 3'(issue_valid) - 3'(head_ready);
        end
    end

    assert property (@(posedge clk) disable iff (!rst) issue_valid |-> !full)
        else $error("issue strobe while the buffer is full.");

    // the unit must report busy after taking an instruction.
    assert property (@(posedge clk) disable iff (!rst)
        alu_dispatch_valid |=> !(alu_dispatch_valid && alu_dispatch.tag == $past(alu_dispatch.tag)))
        else $error("ALU entry dispatched twice.");

    assert property (@(posedge clk) disable iff (!rst)
        mem_dispatch_valid |=> !(mem_dispatch_valid && mem_dispatch.tag == $past(mem_dispatch.tag)))
        else $error("memory entry dispatched twice.");

endmodule

//--- verification/backend_tests.txt
# I test op rd pc imm has_imm value1 value2 tag1 tag2   (test decimal, the rest hex)
# C test rd value  |  R test kind target   (kind 0 branch, 1 jal, 2 jalr)
I 1 00 01 100 0 0 5 7 0 0
I 1 08 02 104 0 0 5 7 0 0
I 1 01 03 108 0 0 f0f0 ff00 0 0
I 1 02 04 10c 0 0 f0f0 0f0f 0 0
I 1 09 05 110 ffff 1 aaaa 0 0 0
I 1 03 06 114 0 0 3 4 0 0
I 1 04 07 118 0 0 80000000 1f 0 0
I 1 07 08 11c 0 0 80000000 4 0 0
I 1 05 09 120 0 0 ffffffff 1 0 0
I 1 06 0a 124 0 0 ffffffff 1 0 0
C 1 01 c
C 1 02 fffffffe
C 1 03 f000
C 1 04 ffff
C 1 05 5555
C 1 06 30
C 1 07 1
C 1 08 f8000000
C 1 09 1
C 1 0a 0
I 2 00 0b 200 20 1 10 0 0 0
I 2 08 0c 204 0 0 0 8 4 0
I 2 03 0d 208 2 1 0 0 5 0
I 2 00 0e 20c 0 0 0 0 6 5
C 2 0b 30
C 2 0c 28
C 2 0d a0
C 2 0e c8
I 3 0e 0f 300 12345000 1 0 0 0 0
I 3 0f 10 304 1000 1 0 0 0 0
I 3 10 01 308 40 1 0 0 0 0
I 3 11 05 30c 10 1 0 0 3 0
C 3 0f 12345000
C 3 10 1304
C 3 01 30c
R 3 1 348
C 3 05 310
R 3 2 31c
I 4 0a 00 400 80 0 9 9 0 0
I 4 1a 00 404 20 0 5 3 0 0
I 4 1b 00 408 10 0 1 ffffffff 0 0
R 4 0 480
R 4 0 418
I 5 19 00 500 8 1 40 deadbeef 0 0
I 5 14 11 504 8 1 40 0 0 0
I 5 00 12 508 0 0 1 2 0 0
I 5 09 13 50c f 1 ff 0 0 0
I 5 02 14 510 0 0 1 2 0 0
I 5 01 15 514 3c 1 ff 0 0 0
I 5 08 16 518 0 0 10 1 0 0
I 5 06 17 51c 0 0 1 2 0 0
C 5 11 deadbeef
C 5 12 3
C 5 13 f0
C 5 14 3
C 5 15 3c
C 5 16 f
C 5 17 1
I 6 14 18 600 8 1 40 0 0 0
I 6 00 19 604 0 0 7 8 0 0
I 6 14 1a 608 0 1 48 0 0 0
I 6 00 1b 60c 0 0 0 1 2 0
I 6 09 1c 610 ffffffff 1 0 0 4 0
C 6 18 deadbeef
C 6 19 f
C 6 1a deadbeef
C 6 1b deadbef0
C 6 1c 21524110

//--- verification/commit_checker.sv
`include "ooo_settings.svh"

module commit_checker (
    input logic               clk,
    input logic               rst,
    input ooo_pkg::issue_t    issue,
    input logic               issue_valid,
    input logic               full,
    input ooo_pkg::rob_tag_t  issued_tag,
    input ooo_pkg::commit_t   commit,
    input ooo_pkg::redirect_t redirect
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int full_level = 5;  // occupied entries that raise full.

    typedef struct {
        int          test;
        bit          is_redirect;
        logic [31:0] a;  // rd, or the redirect kind.
        logic [31:0] b;  // value, or the target.
    } expect_t;

    typedef struct {
        ooo_pkg::rob_tag_t tag;
        logic [4:0]        rd;
    } entry_t;

    expect_t    expected [$];
    entry_t     in_flight [$];  // allocated and not yet known to be retired.
    int         outstanding = 0;
    int         error_count = 0;
    int         tests_passed = 0;
    int         tests_failed = 0;
    int         test_errors = 0;
    int         next_tag = 1;
    logic       issue_seen = 1'b0;
    logic [4:0] issue_rd = '0;

    task automatic add_expected(input int test, input bit is_redirect,
                                input logic [31:0] a, input logic [31:0] b);
        expected.push_back('{test: test, is_redirect: is_redirect, a: a, b: b});
        outstanding++;
    endtask

    function automatic string event_name(bit is_redirect);
        return is_redirect ? "redirect" : "commit";
    endfunction

    task automatic report_mismatch(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        error_count++;
        test_errors++;
    endtask

    // tags are handed out in order and wrap from the last entry to 1.
    task automatic note_issue();
        if (issued_tag !== ooo_pkg::rob_tag_t'(next_tag)) begin
            report_mismatch($sformatf("issued tag %0d, expected %0d", issued_tag, next_tag));
        end
        in_flight.push_back('{tag: ooo_pkg::rob_tag_t'(next_tag), rd: issue_rd});
        next_tag = (next_tag == `OOO_ROB_DEPTH) ? 1 : next_tag + 1;
    endtask

    // entries without a destination retire silently ahead of a commit.
    task automatic match_commit_tag();
        while (in_flight.size() != 0 && in_flight[0].rd == '0) begin
            in_flight.delete(0);
        end
        if (in_flight.size() == 0) begin
            $display("a commit arrived while no register-writing entry was in flight");
            error_count++;
            test_errors++;
        end else begin
            if (commit.tag !== in_flight[0].tag) begin
                report_mismatch($sformatf("commit tag %0d, expected %0d", commit.tag,
                                          in_flight[0].tag));
            end
            in_flight.delete(0);
        end
    endtask

    // entries from the oldest pending register write onward are still occupied.
    task automatic verify_full_level();
        int occupied;
        occupied = 0;
        for (int i = 0; i < in_flight.size(); i++) begin
            if (in_flight[i].rd != '0) begin
                occupied = in_flight.size() - i;
                break;
            end
        end
        if (occupied >= full_level && full !== 1'b1) begin
            report_mismatch($sformatf("full low with %0d entries occupied", occupied));
        end
        if (in_flight.size() < full_level && full !== 1'b0) begin
            report_mismatch($sformatf("full high with at most %0d entries occupied",
                                      in_flight.size()));
        end
    endtask

    task automatic check_event(input bit is_redirect, input logic [31:0] a,
                               input logic [31:0] b);
        expect_t exp;
        if (expected.size() == 0) begin
            $display("an unexpected %s arrived after every expected record was used",
                     event_name(is_redirect));
            error_count++;
            return;
        end
        exp = expected.pop_front();
        outstanding--;
        if (exp.is_redirect != is_redirect || exp.a !== a || exp.b !== b) begin
            $display("[ERROR] %0t: test %0d expected %s %0h/%h, got %s %0h/%h", $time,
                     exp.test, event_name(exp.is_redirect), exp.a, exp.b,
                     event_name(is_redirect), a, b);
            error_count++;
            test_errors++;
        end
        // last record of a test closes it.
        if (expected.size() == 0 || expected[0].test != exp.test) begin
            if (test_errors == 0) begin
                $display("test %0d passed", exp.test);
                tests_passed++;
            end else begin
                $display("test %0d failed with %0d errors", exp.test, test_errors);
                tests_failed++;
            end
            test_errors = 0;
        end
    endtask

    // the buffer allocates on this edge, so the tag shows after it.
    always @(posedge clk) begin
        issue_seen <= rst && issue_valid;
        issue_rd <= issue.rd;
    end

    // outputs are registered, so the falling edge sees them settled.
    always @(negedge clk) begin
        if (rst) begin
            if (issue_seen) begin
                note_issue();
            end
            if (commit.valid) begin
                match_commit_tag();
                check_event(1'b0, {27'b0, commit.rd}, commit.value);
            end
            if (redirect.valid) begin
                check_event(1'b1, {30'b0, redirect.kind}, redirect.target);
            end
            verify_full_level();
        end
    end

endmodule

//--- verification/ooo_backend_tb.sv
module ooo_backend_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic               clk;
    logic               rst;
    logic               issue_valid;
    logic               full;
    logic               loaded = 1'b0;
    logic               load_ok;
    ooo_pkg::issue_t    issue;
    ooo_pkg::rob_tag_t  issued_tag;
    ooo_pkg::commit_t   commit;
    ooo_pkg::redirect_t redirect;
    ooo_pkg::issue_t    issue_q [$];

    ooo_backend_top dut (
        .clk         (clk),
        .rst         (rst),
        .issue       (issue),
        .issue_valid (issue_valid),
        .full        (full),
        .issued_tag  (issued_tag),
        .commit      (commit),
        .redirect    (redirect)
    );

    commit_checker u_checker (
        .clk         (clk),
        .rst         (rst),
        .issue       (issue),
        .issue_valid (issue_valid),
        .full        (full),
        .issued_tag  (issued_tag),
        .commit      (commit),
        .redirect    (redirect)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // issue records go to the stimulus queue, C and R records to the checker.
    task automatic read_tests(output logic ok);
        int              fd;
        int              test;
        string           line;
        string           kind;
        logic [31:0]     f [9];
        ooo_pkg::issue_t rec;
        fd = $fopen("verification/backend_tests.txt", "r");
        ok = fd != 0;
        while (ok && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            void'($sscanf(line, "%s %d %h %h %h %h %h %h %h %h %h", kind, test,
                          f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]));
            if (kind == "I") begin
                rec.op = ooo_pkg::op_e'(f[0][4:0]);
                rec.rd = f[1][4:0];
                rec.pc = f[2];
                rec.imm = f[3];
                rec.has_imm = f[4][0];
                rec.value1 = f[5];
                rec.value2 = f[6];
                rec.tag1 = f[7][2:0];
                rec.tag2 = f[8][2:0];
                issue_q.push_back(rec);
            end else begin
                u_checker.add_expected(test, kind == "R", f[0], f[1]);
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
    endtask

    task automatic drive_issue(input ooo_pkg::issue_t rec);
        @(posedge clk);
        #1;
        while (full) begin
            issue_valid = 1'b0;
            @(posedge clk);
            #1;
        end
        issue = rec;
        issue_valid = 1'b1;
    endtask

    initial begin
        issue = '0;
        issue_valid = 1'b0;
        rst = 1'b0;
        read_tests(load_ok);
        if (!load_ok) begin
            $display("could not open the test file verification/backend_tests.txt");
            $display("Test FAILED");
            $finish;
        end else begin
            loaded = 1'b1;
            repeat (4) @(posedge clk);
            #1;
            rst = 1'b1;
            foreach (issue_q[i]) begin
                drive_issue(issue_q[i]);
            end
            @(posedge clk);
            #1;
            issue_valid = 1'b0;
            while (u_checker.outstanding != 0) begin
                @(posedge clk);
            end
            repeat (10) @(posedge clk);  // room for a stray commit.
            $display("tests passed %0d, failed %0d, errors %0d", u_checker.tests_passed,
                     u_checker.tests_failed, u_checker.error_count);
            if (u_checker.error_count == 0 && u_checker.tests_failed == 0) begin
                $display("Test OK");
            end else begin
                $display("Test FAILED");
            end
            $finish;
        end
    end

    initial begin
        longint cycles;
        wait (loaded);
        cycles = 200 * issue_q.size();
        #(cycles * 8);
        $display("timeout, the run did not finish within %0d cycles", cycles);
        $display("Test FAILED");
        $finish;
    end

endmodule
